//--- include/clic_defines.svh
`ifndef CLIC_DEFINES_SVH
`define CLIC_DEFINES_SVH

//////////////////////////////////////////////////
// CLIC sizing
//////////////////////////////////////////////////

// Number of edge-pulsed interrupt sources
`define CLIC_NUM_SRC 16

// Interrupt ID width, must cover CLIC_NUM_SRC
`define CLIC_ID_WIDTH 4

// Interrupt level width
// Matches mintthresh and mintstatus.mil
`define CLIC_LVL_WIDTH 8

`endif

//--- src/clic_pkg.sv
package clic_pkg;

  `include "clic_defines.svh"

  //////////////////////////////////////////////////
  // Privilege encoding
  //////////////////////////////////////////////////

  // Only machine mode is implemented
  // User encoding kept so priv compares stay meaningful
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  //////////////////////////////////////////////////
  // Interrupt presented by the arbiter
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                       valid;
    logic [`CLIC_ID_WIDTH-1:0]  id;
    logic [`CLIC_LVL_WIDTH-1:0] level;
    priv_lvl_e                  priv;
    logic                       shv;    // Selective hardware vectoring
  } clic_irq_t;

  // Static per-source configuration
  typedef struct packed {
    logic [`CLIC_LVL_WIDTH-1:0] level;
    priv_lvl_e                  priv;
    logic                       shv;
  } clic_src_cfg_t;

endpackage

//--- src/csr_pkg.sv
package csr_pkg;

  //////////////////////////////////////////////////
  // CSR addresses handled by the CSR block
  //////////////////////////////////////////////////

  // mnxti has its own read pulse, no address here
  typedef enum logic [11:0] {
    CSR_MSTATUS    = 12'h300,
    CSR_MCAUSE     = 12'h342,
    CSR_MINTTHRESH = 12'h347,
    CSR_MINTSTATUS = 12'hFB1
  } csr_addr_e;

  // Only the machine interrupt level is implemented
  typedef struct packed {
    logic [7:0]  mil;       // Bits 31:24
    logic [23:0] zero0;
  } mintstatus_t;

  //////////////////////////////////////////////////
  // mcause in CLIC mode
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        irq;       // Bit 31, interrupt flag
    logic        minhv;     // Bit 30, hardware vector fetch in progress
    logic [1:0]  mpp;       // Bits 29:28, previous privilege
    logic        mpie;      // Bit 27, previous interrupt enable
    logic [2:0]  zero0;
    logic [7:0]  mpil;      // Bits 23:16, previous interrupt level
    logic [3:0]  zero1;
    logic [11:0] exccode;   // Bits 11:0, interrupt ID
  } mcause_t;

endpackage

//--- src/clic_arbiter.sv
`timescale 1ns/10ps

`include "clic_defines.svh"

module clic_arbiter (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [`CLIC_NUM_SRC-1:0]                     src_pulse_i,
  input  clic_pkg::clic_src_cfg_t [`CLIC_NUM_SRC-1:0]  src_cfg_i,
  input  logic                                         claim_i,
  input  logic [`CLIC_ID_WIDTH-1:0]                    claim_id_i,
  output clic_pkg::clic_irq_t                          clic_irq_o
);

  import clic_pkg::*;

  // Pending bit per source
  logic [`CLIC_NUM_SRC-1:0]   pending_q;
  logic [`CLIC_NUM_SRC-1:0]   pending_d;
  // One-hot clear from a claim
  logic [`CLIC_NUM_SRC-1:0]   clr_vec;

  // Scan result
  logic                       sel_found;
  logic [`CLIC_ID_WIDTH-1:0]  sel_idx;
  logic [`CLIC_LVL_WIDTH-1:0] sel_level;

  //////////////////////////////////////////////////
  // Pending bits
  //////////////////////////////////////////////////

  // Decode the claimed ID into a clear mask
  always_comb begin
    clr_vec = '0;
    if (claim_i) begin
      clr_vec[claim_id_i] = 1'b1;
    end
  end

  // A new pulse wins over a clear of the same source
  assign pending_d = src_pulse_i | (pending_q & ~clr_vec);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  //////////////////////////////////////////////////
  // Max-level selection
  //////////////////////////////////////////////////

  // Strict compare keeps the lowest ID on equal levels
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    sel_level = '0;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (pending_q[i] && (!sel_found || (src_cfg_i[i].level > sel_level))) begin
        sel_found = 1'b1;
        sel_idx   = i[`CLIC_ID_WIDTH-1:0];
        sel_level = src_cfg_i[i].level;
      end
    end
  end

  // Present the winner, all zero when nothing is pending
  always_comb begin
    clic_irq_o = '0;
    if (sel_found) begin
      clic_irq_o.valid = 1'b1;
      clic_irq_o.id    = sel_idx;
      clic_irq_o.level = sel_level;
      clic_irq_o.priv  = src_cfg_i[sel_idx].priv;
      clic_irq_o.shv   = src_cfg_i[sel_idx].shv;
    end
  end

endmodule

//--- src/clic_int_controller.sv
`timescale 1ns/10ps

`include "clic_defines.svh"

module clic_int_controller (
  input  logic                        clk,
  input  logic                        rst_n,

  // From the arbiter
  input  clic_pkg::clic_irq_t         clic_irq_i,

  // From the CSR block
  input  logic                        m_ie_i,
  input  logic [7:0]                  mintthresh_i,
  input  csr_pkg::mintstatus_t        mintstatus_i,
  input  csr_pkg::mcause_t            mcause_i,

  // To the core
  output logic                        irq_req_o,
  output logic                        irq_wu_o,
  output logic [`CLIC_ID_WIDTH-1:0]   irq_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0]  irq_level_o,
  output logic                        irq_shv_o,

  // To the CSR block for mnxti
  output logic                        mnxti_pending_o,
  output logic [`CLIC_ID_WIDTH-1:0]   mnxti_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0]  mnxti_level_o
);

  import clic_pkg::*;

  // Registered copy of the presented interrupt
  clic_irq_t  irq_q;
  // max(mintthresh, mil)
  logic [7:0] eff_level;

  //////////////////////////////////////////////////
  // Input flops
  //////////////////////////////////////////////////

  // Valid follows every cycle, payload holds while nothing is presented
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q      <= '0;
      irq_q.priv <= PRIV_LVL_M;
    end else begin
      irq_q.valid <= clic_irq_i.valid;
      if (clic_irq_i.valid) begin
        irq_q.id    <= clic_irq_i.id;
        irq_q.level <= clic_irq_i.level;
        irq_q.priv  <= clic_irq_i.priv;
        irq_q.shv   <= clic_irq_i.shv;
      end
    end
  end

  assign eff_level = (mintthresh_i > mintstatus_i.mil) ? mintthresh_i : mintstatus_i.mil;

  // Take request from the registered interrupt
  assign irq_req_o = irq_q.valid && (irq_q.level > eff_level) && m_ie_i;

  // Wake-up looks at the live input and ignores mie
  assign irq_wu_o = clic_irq_i.valid && (clic_irq_i.level > eff_level);

  assign irq_id_o    = irq_q.id;
  assign irq_level_o = irq_q.level;
  assign irq_shv_o   = irq_q.shv;

  //////////////////////////////////////////////////
  // mnxti availability
  //////////////////////////////////////////////////

  // Non-vectored machine interrupt above both mpil and mintthresh
  assign mnxti_pending_o = (irq_q.priv == PRIV_LVL_M)    &&
                           (irq_q.level > mcause_i.mpil) &&
                           (irq_q.level > mintthresh_i)  &&
                           !irq_q.shv                    &&
                           irq_q.valid;

  assign mnxti_id_o    = irq_q.id;
  assign mnxti_level_o = irq_q.level;

endmodule

//--- src/clic_csr.sv
`timescale 1ns/10ps

`include "clic_defines.svh"

module clic_csr (
  input  logic                        clk,
  input  logic                        rst_n,

  // Software CSR port
  input  logic                        csr_we_i,
  input  csr_pkg::csr_addr_e          csr_addr_i,
  input  logic [31:0]                 csr_wdata_i,

  // Core events
  input  logic                        irq_ack_i,
  input  logic                        mret_i,
  input  logic                        mnxti_rd_i,

  // Interrupt being taken on ack
  input  logic [`CLIC_ID_WIDTH-1:0]   irq_id_i,
  input  logic [`CLIC_LVL_WIDTH-1:0]  irq_level_i,

  // mnxti candidate from the controller
  input  logic                        mnxti_pending_i,
  input  logic [`CLIC_ID_WIDTH-1:0]   mnxti_id_i,
  input  logic [`CLIC_LVL_WIDTH-1:0]  mnxti_level_i,

  output logic                        m_ie_o,
  output logic [7:0]                  mintthresh_o,
  output csr_pkg::mintstatus_t        mintstatus_o,
  output csr_pkg::mcause_t            mcause_o,
  output logic [31:0]                 csr_rdata_o,
  output logic [31:0]                 mnxti_rdata_o,
  output logic                        claim_o
);

  import csr_pkg::*;

  logic        m_ie_q;
  logic [7:0]  mintthresh_q;
  mintstatus_t mintstatus_q;
  mcause_t     mcause_q;
  logic        mnxti_take;

  // mnxti only has side effects when something qualifies
  assign mnxti_take = mnxti_rd_i && mnxti_pending_i;
  assign claim_o    = irq_ack_i || mnxti_take;

  //////////////////////////////////////////////////
  // Register update, ack > mret > mnxti > write
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_ie_q       <= 1'b0;
      mintthresh_q <= '0;
      mintstatus_q <= '0;
      mcause_q     <= '0;
    end else if (irq_ack_i) begin
      // Save old context, then enter the handler level
      mcause_q.irq     <= 1'b1;
      mcause_q.mpp     <= 2'b11;
      mcause_q.mpie    <= m_ie_q;
      mcause_q.mpil    <= mintstatus_q.mil;
      mcause_q.exccode <= 12'(irq_id_i);
      mintstatus_q.mil <= irq_level_i;
      m_ie_q           <= 1'b0;
    end else if (mret_i) begin
      mintstatus_q.mil <= mcause_q.mpil;
      m_ie_q           <= mcause_q.mpie;
    end else if (mnxti_take) begin
      mintstatus_q.mil <= mnxti_level_i;
      mcause_q.exccode <= 12'(mnxti_id_i);
    end else if (csr_we_i) begin
      case (csr_addr_i)
        // mpie and mpp are mirrors of the mcause fields
        CSR_MSTATUS: begin
          m_ie_q        <= csr_wdata_i[3];
          mcause_q.mpie <= csr_wdata_i[7];
          mcause_q.mpp  <= csr_wdata_i[12:11];
        end
        CSR_MINTTHRESH: mintthresh_q     <= csr_wdata_i[7:0];
        CSR_MINTSTATUS: mintstatus_q.mil <= csr_wdata_i[31:24];
        CSR_MCAUSE: begin
          mcause_q.irq     <= csr_wdata_i[31];
          mcause_q.mpp     <= csr_wdata_i[29:28];
          mcause_q.mpie    <= csr_wdata_i[27];
          mcause_q.mpil    <= csr_wdata_i[23:16];
          mcause_q.exccode <= csr_wdata_i[11:0];
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[3]     = m_ie_q;
        csr_rdata_o[7]     = mcause_q.mpie;
        csr_rdata_o[12:11] = mcause_q.mpp;
      end
      CSR_MINTTHRESH: csr_rdata_o[7:0] = mintthresh_q;
      CSR_MINTSTATUS: csr_rdata_o      = mintstatus_q;
      CSR_MCAUSE:     csr_rdata_o      = mcause_q;
      default:        csr_rdata_o      = '0;
    endcase
  end

  // ID of the next interrupt or zero
  assign mnxti_rdata_o = mnxti_pending_i ? 32'(mnxti_id_i) : 32'd0;

  assign m_ie_o       = m_ie_q;
  assign mintthresh_o = mintthresh_q;
  assign mintstatus_o = mintstatus_q;
  assign mcause_o     = mcause_q;

endmodule

//--- src/clic_irq_top.sv
`timescale 1ns/10ps

`include "clic_defines.svh"

module clic_irq_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [`CLIC_NUM_SRC-1:0]                     src_pulse_i,
  input  clic_pkg::clic_src_cfg_t [`CLIC_NUM_SRC-1:0]  src_cfg_i,
  input  logic                                         irq_ack_i,
  input  logic                                         mret_i,
  input  logic                                         mnxti_rd_i,
  input  logic                                         csr_we_i,
  input  csr_pkg::csr_addr_e                           csr_addr_i,
  input  logic [31:0]                                  csr_wdata_i,
  output logic                                         irq_req_o,
  output logic                                         irq_wu_o,
  output logic [`CLIC_ID_WIDTH-1:0]                    irq_id_o,
  output logic [`CLIC_LVL_WIDTH-1:0]                   irq_level_o,
  output logic                                         irq_shv_o,
  output logic [31:0]                                  csr_rdata_o,
  output logic [31:0]                                  mnxti_rdata_o
);

  import clic_pkg::*;
  import csr_pkg::*;

  // Arbiter to controller
  clic_irq_t                  clic_irq;

  // CSR block to controller
  logic                       m_ie;
  logic [7:0]                 mintthresh;
  mintstatus_t                mintstatus;
  mcause_t                    mcause;

  // Controller to CSR block
  logic                       mnxti_pending;
  logic [`CLIC_ID_WIDTH-1:0]  mnxti_id;
  logic [`CLIC_LVL_WIDTH-1:0] mnxti_level;

  // Clears the pending bit of the registered ID
  logic                       claim;

  clic_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .src_pulse_i (src_pulse_i),
    .src_cfg_i   (src_cfg_i),
    .claim_i     (claim),
    .claim_id_i  (irq_id_o),
    .clic_irq_o  (clic_irq)
  );

  clic_int_controller u_int_controller (
    .clk             (clk),
    .rst_n           (rst_n),
    .clic_irq_i      (clic_irq),
    .m_ie_i          (m_ie),
    .mintthresh_i    (mintthresh),
    .mintstatus_i    (mintstatus),
    .mcause_i        (mcause),
    .irq_req_o       (irq_req_o),
    .irq_wu_o        (irq_wu_o),
    .irq_id_o        (irq_id_o),
    .irq_level_o     (irq_level_o),
    .irq_shv_o       (irq_shv_o),
    .mnxti_pending_o (mnxti_pending),
    .mnxti_id_o      (mnxti_id),
    .mnxti_level_o   (mnxti_level)
  );

  clic_csr u_csr (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_we_i        (csr_we_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .irq_ack_i       (irq_ack_i),
    .mret_i          (mret_i),
    .mnxti_rd_i      (mnxti_rd_i),
    .irq_id_i        (irq_id_o),
    .irq_level_i     (irq_level_o),
    .mnxti_pending_i (mnxti_pending),
    .mnxti_id_i      (mnxti_id),
    .mnxti_level_i   (mnxti_level),
    .m_ie_o          (m_ie),
    .mintthresh_o    (mintthresh),
    .mintstatus_o    (mintstatus),
    .mcause_o        (mcause),
    .csr_rdata_o     (csr_rdata_o),
    .mnxti_rdata_o   (mnxti_rdata_o),
    .claim_o         (claim)
  );

endmodule

//--- tb/clic_irq_tb.sv
`timescale 1ns/10ps

`include "clic_defines.svh"

module clic_irq_tb;

  import clic_pkg::*;
  import csr_pkg::*;

  localparam int WAIT_LIMIT = 20;

  logic                              clk;
  logic                              rst_n;
  logic [`CLIC_NUM_SRC-1:0]          src_pulse;
  clic_src_cfg_t [`CLIC_NUM_SRC-1:0] src_cfg;
  logic                              irq_ack;
  logic                              mret;
  logic                              mnxti_rd;
  logic                              csr_we;
  csr_addr_e                         csr_addr;
  logic [31:0]                       csr_wdata;
  logic                              irq_req;
  logic                              irq_wu;
  logic [`CLIC_ID_WIDTH-1:0]         irq_id;
  logic [`CLIC_LVL_WIDTH-1:0]        irq_level;
  logic                              irq_shv;
  logic [31:0]                       csr_rdata;
  logic [31:0]                       mnxti_rdata;

  // Reference model of the CSRs and pending bits
  logic                              m_mie;
  logic                              m_mpie;
  logic [1:0]                        m_mpp;
  logic                              m_irq;
  logic [7:0]                        m_mpil;
  logic [11:0]                       m_exc;
  logic [7:0]                        m_mil;
  logic [7:0]                        m_thresh;
  logic [`CLIC_NUM_SRC-1:0]          model_pend;

  int seed = 32'h7ddbf3e0;
  int errors;
  int checks;
  int tests;
  int tests_failed;
  int test_err_start;

  clic_irq_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .src_pulse_i   (src_pulse),
    .src_cfg_i     (src_cfg),
    .irq_ack_i     (irq_ack),
    .mret_i        (mret),
    .mnxti_rd_i    (mnxti_rd),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .irq_req_o     (irq_req),
    .irq_wu_o      (irq_wu),
    .irq_id_o      (irq_id),
    .irq_level_o   (irq_level),
    .irq_shv_o     (irq_shv),
    .csr_rdata_o   (csr_rdata),
    .mnxti_rdata_o (mnxti_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taking an interrupt clears mie so the request is gone next cycle
  ack_drops_req: assert property (@(posedge clk) disable iff (!rst_n) irq_ack |=> !irq_req)
    else begin
      $display("MISMATCH t=%0t irq_req_o expected 0x0 got 0x1 after ack", $time);
      errors++;
    end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Move to the drive point 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("MISMATCH t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic set_cfg(input logic [3:0] id, input logic [7:0] lvl, input logic shv);
    src_cfg[id].level = lvl;
    src_cfg[id].priv  = PRIV_LVL_M;
    src_cfg[id].shv   = shv;
  endtask

  // Highest level wins and the downward scan lets the lowest ID keep ties
  function automatic void pick_winner(output logic [3:0] id, output logic [7:0] lvl);
    id  = '0;
    lvl = '0;
    for (int i = `CLIC_NUM_SRC - 1; i >= 0; i--) begin
      if (model_pend[i] && src_cfg[i].level >= lvl) begin
        id  = 4'(i);
        lvl = src_cfg[i].level;
      end
    end
  endfunction

  // One-cycle pulse that leaves the bench in the cycle after it
  task automatic pulse_src(input logic [`CLIC_NUM_SRC-1:0] mask);
    src_pulse  = mask;
    model_pend = model_pend | mask;
    tick();
    src_pulse  = '0;
  endtask

  task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    tick();
    csr_we    = 1'b0;
    case (addr)
      CSR_MSTATUS: begin
        m_mie  = data[3];
        m_mpie = data[7];
        m_mpp  = data[12:11];
      end
      CSR_MINTTHRESH: m_thresh = data[7:0];
      CSR_MINTSTATUS: m_mil = data[31:24];
      default: ;
    endcase
  endtask

  task automatic read_csr(input csr_addr_e addr, input string name, input logic [31:0] exp);
    csr_addr = addr;
    #1;
    check_value(name, exp, csr_rdata);
    tick();
  endtask

  task automatic check_csrs();
    read_csr(CSR_MSTATUS, "mstatus", {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0});
    read_csr(CSR_MINTTHRESH, "mintthresh", {24'b0, m_thresh});
    read_csr(CSR_MINTSTATUS, "mintstatus", {m_mil, 24'b0});
    read_csr(CSR_MCAUSE, "mcause", {m_irq, 1'b0, m_mpp, m_mpie, 3'b0, m_mpil, 4'b0, m_exc});
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    while (!irq_req && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!irq_req) begin
      $display("ERROR t=%0t timeout, irq_req_o did not rise in %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  // Ack in the current cycle while the model saves context and enters the level
  task automatic ack_irq(input logic [3:0] id, input logic [7:0] lvl);
    irq_ack = 1'b1;
    tick();
    irq_ack = 1'b0;
    m_mpil  = m_mil;
    m_mpie  = m_mie;
    m_mpp   = 2'b11;
    m_irq   = 1'b1;
    m_exc   = 12'(id);
    m_mil   = lvl;
    m_mie   = 1'b0;
    model_pend[id] = 1'b0;
  endtask

  task automatic do_mret();
    mret = 1'b1;
    tick();
    mret  = 1'b0;
    m_mil = m_mpil;
    m_mie = m_mpie;
  endtask

  // Wait for the expected winner, take it and return from the handler
  task automatic take_irq();
    logic [3:0] id;
    logic [7:0] lvl;
    pick_winner(id, lvl);
    wait_req();
    check_value("irq_id_o", 32'(id), 32'(irq_id));
    check_value("irq_level_o", 32'(lvl), 32'(irq_level));
    check_value("irq_shv_o", 32'(src_cfg[id].shv), 32'(irq_shv));
    ack_irq(id, lvl);
    check_value("irq_req_o", 32'd0, 32'(irq_req));
    do_mret();
  endtask

  task automatic mnxti_read(input logic [31:0] exp);
    logic [3:0] id;
    logic [7:0] lvl;
    mnxti_rd = 1'b1;
    #1;
    check_value("mnxti_rdata_o", exp, mnxti_rdata);
    tick();
    mnxti_rd = 1'b0;
    if (exp != 32'd0) begin
      pick_winner(id, lvl);
      m_mil = lvl;
      m_exc = 12'(id);
      model_pend[id] = 1'b0;
    end
  endtask

  task automatic start_test();
    test_err_start = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_start) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, name, errors - test_err_start);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    src_pulse  = '0;
    src_cfg    = '0;
    irq_ack    = 1'b0;
    mret       = 1'b0;
    mnxti_rd   = 1'b0;
    csr_we     = 1'b0;
    csr_addr   = CSR_MSTATUS;
    csr_wdata  = '0;
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mpp      = '0;
    m_irq      = 1'b0;
    m_mpil     = '0;
    m_exc      = '0;
    m_mil      = '0;
    m_thresh   = '0;
    model_pend = '0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test();
    check_value("irq_req_o", 32'd0, 32'(irq_req));
    check_value("irq_wu_o", 32'd0, 32'(irq_wu));
    check_value("irq_id_o", 32'd0, 32'(irq_id));
    check_value("irq_level_o", 32'd0, 32'(irq_level));
    check_value("irq_shv_o", 32'd0, 32'(irq_shv));
    check_csrs();
    end_test("reset");

    // Level 0x40 over threshold 0x20 with shv and then a level equal to it
    start_test();
    csr_write(CSR_MSTATUS, 32'h8);
    csr_write(CSR_MINTTHRESH, 32'h20);
    set_cfg(4'd3, 8'h40, 1'b1);
    pulse_src(16'h0008);
    check_value("irq_wu_o", 32'd1, 32'(irq_wu));
    check_value("irq_req_o", 32'd0, 32'(irq_req));
    tick();
    check_value("irq_req_o", 32'd1, 32'(irq_req));
    take_irq();
    set_cfg(4'd5, 8'h20, 1'b0);
    pulse_src(16'h0020);
    repeat (3) begin
      check_value("irq_wu_o", 32'd0, 32'(irq_wu));
      check_value("irq_req_o", 32'd0, 32'(irq_req));
      tick();
    end
    csr_write(CSR_MINTTHRESH, 32'h10);
    take_irq();
    csr_write(CSR_MINTTHRESH, 32'h0);
    end_test("threshold gating");

    // Small random levels so that ties are likely
    start_test();
    for (int i = 0; i < 8; i++) begin
      set_cfg(4'(i), 8'(($random(seed) & 7) + 1), 1'b0);
    end
    pulse_src(16'h00FF);
    repeat (8) take_irq();
    check_value("irq_wu_o", 32'd0, 32'(irq_wu));
    end_test("arbitration");

    start_test();
    csr_write(CSR_MINTSTATUS, 32'h1000_0000);
    set_cfg(4'd9, 8'h50, 1'b0);
    pulse_src(16'h0200);
    wait_req();
    check_value("irq_id_o", 32'd9, 32'(irq_id));
    ack_irq(4'd9, 8'h50);
    check_value("irq_req_o", 32'd0, 32'(irq_req));
    check_csrs();
    do_mret();
    check_csrs();
    csr_write(CSR_MINTSTATUS, 32'h0);
    end_test("ack and mret");

    // mpil is 0x10 here as left by the previous ack
    start_test();
    csr_write(CSR_MSTATUS, 32'h0);
    set_cfg(4'd11, 8'h60, 1'b0);
    pulse_src(16'h0800);
    tick();
    mnxti_read(32'd11);
    tick();
    check_value("mnxti_rdata_o", 32'd0, mnxti_rdata);
    check_csrs();
    // Level at or below mpil
    set_cfg(4'd13, 8'h08, 1'b0);
    pulse_src(16'h2000);
    tick();
    mnxti_read(32'd0);
    check_csrs();
    // Vectored source is never returned
    set_cfg(4'd12, 8'h70, 1'b1);
    pulse_src(16'h1000);
    tick();
    mnxti_read(32'd0);
    check_csrs();
    csr_write(CSR_MINTSTATUS, 32'h0);
    csr_write(CSR_MSTATUS, 32'h8);
    take_irq();
    take_irq();
    end_test("mnxti");

    start_test();
    csr_write(CSR_MSTATUS, 32'h0);
    set_cfg(4'd14, 8'h30, 1'b0);
    pulse_src(16'h4000);
    repeat (4) begin
      check_value("irq_wu_o", 32'd1, 32'(irq_wu));
      check_value("irq_req_o", 32'd0, 32'(irq_req));
      tick();
    end
    csr_write(CSR_MSTATUS, 32'h8);
    take_irq();
    end_test("global enable");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
src/clic_pkg.sv
src/csr_pkg.sv
src/clic_arbiter.sv
src/clic_int_controller.sv
src/clic_csr.sv
src/clic_irq_top.sv
tb/clic_irq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the CLIC testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module clic_irq_tb -o clic_irq_sim

./obj_dir/clic_irq_sim > sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
